//--- all.f
design/core_pkg.sv
design/alu.sv
design/fetch_unit.sv
design/reg_file.sv
design/exec_pipe.sv
design/pipe_core.sv
verif/tb_pipe_core.sv

//--- Bender.yml
package:
  name: pipe_core

sources:
  - files:
      - design/core_pkg.sv
      - design/alu.sv
      - design/fetch_unit.sv
      - design/reg_file.sv
      - design/exec_pipe.sv
      - design/pipe_core.sv
  - target: test
    files:
      - verif/tb_pipe_core.sv

//--- verif/tb_pipe_core.sv
//##########################################################################
// testbench for the pipelined core
//   clock, reset and instruction memory model
//   directed and seeded random programs
//   isa reference model, writeback compare, watchdog, report
//##########################################################################

`timescale 1ns/10ps

module tb_pipe_core
    import core_pkg::*;
();

    localparam word_t RESET_PC = '0;
    localparam int    MAX_PROG = 256;

    logic     clock;
    logic     rst_n;
    word_t    imem_addr;
    word_t    imem_data;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;

    // program image and expected writeback sequence
    word_t    prog [MAX_PROG];
    int       prog_len;
    reg_idx_t exp_reg [$];
    word_t    exp_val [$];
    int       got;
    word_t    loop_pc;
    string    test_name;
    integer   seed;
    // watchdog budget in cycles
    int       budget;
    int       cycles;
    int       value_errs;
    int       extra_errs;
    int       missing_errs;

    pipe_core #(
        .RESET_PC (RESET_PC),
        .NUM_REGS (32)
    ) DUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // instruction memory, answers 1 ns after the edge
    always @(posedge clock) begin
        #1;
        if (imem_addr < word_t'(prog_len)) begin
            imem_data = prog[imem_addr[7:0]];
        end else begin
            imem_data = NOP_WORD;
        end
    end

    function automatic word_t rtype_word(alu_op_t func, reg_idx_t rd, reg_idx_t rs,
                                         reg_idx_t rt);
        return {OP_RTYPE, rd, rs, rt, 5'b0, func, 2'b0};
    endfunction

    function automatic word_t addi_word(reg_idx_t rd, reg_idx_t rs, int imm);
        return {OP_ADDI, rd, rs, imm[16:0]};
    endfunction

    // bne compares rs with rd
    function automatic word_t bne_word(reg_idx_t rd, reg_idx_t rs, int offset);
        return {OP_BNE, rd, rs, offset[16:0]};
    endfunction

    function automatic word_t jump_word(int target);
        return {OP_J, target[26:0]};
    endfunction

    task automatic append_instr(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // in-order isa model, fills the expected write list
    // returns the number of executed instructions
    function automatic int ref_run();
        word_t    arch_regs [32];
        word_t    pc;
        word_t    instr;
        word_t    imm;
        word_t    res;
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        logic     writes;
        int       steps;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end
        exp_reg.delete();
        exp_val.delete();
        pc = RESET_PC;
        steps = 0;
        while (steps < 1000) begin
            instr = (pc < word_t'(prog_len)) ? prog[pc[7:0]] : NOP_WORD;
            op = instr[31:27];
            rd = instr[26:22];
            rs = instr[21:17];
            rt = instr[16:12];
            imm = {{15{instr[16]}}, instr[16:0]};
            res = '0;
            writes = 1'b0;
            steps++;
            case (op)
                OP_RTYPE: begin
                    writes = 1'b1;
                    case (instr[6:2])
                        ALU_ADD: res = arch_regs[rs] + arch_regs[rt];
                        ALU_SUB: res = arch_regs[rs] - arch_regs[rt];
                        ALU_AND: res = arch_regs[rs] & arch_regs[rt];
                        ALU_OR:  res = arch_regs[rs] | arch_regs[rt];
                        default: res = '0;
                    endcase
                    pc = pc + 1;
                end
                OP_ADDI: begin
                    writes = 1'b1;
                    res = arch_regs[rs] + imm;
                    pc = pc + 1;
                end
                OP_BNE: begin
                    pc = (arch_regs[rs] != arch_regs[rd]) ? pc + 1 + imm : pc + 1;
                end
                OP_J: begin
                    // jump to itself ends the program
                    if (word_t'(instr[26:0]) == pc) begin
                        loop_pc = pc;
                        return steps;
                    end
                    pc = word_t'(instr[26:0]);
                end
                default: pc = pc + 1;
            endcase
            if (writes && (rd != '0)) begin
                arch_regs[rd] = res;
                exp_reg.push_back(rd);
                exp_val.push_back(res);
            end
        end
        loop_pc = pc;
        return steps;
    endfunction

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            value_errs++;
            $display("[FAIL] %s %s expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_reg(input string what, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            value_errs++;
            $display("[FAIL] %s %s expected r%0d actual r%0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            value_errs++;
            $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // compare each write against the next expected pair
    always @(posedge clock) begin
        if (rst_n && wb_en) begin
            if (wb_reg == '0) begin
                extra_errs++;
                $display("%s: write strobe raised for r0", test_name);
            end
            if (got >= exp_reg.size()) begin
                extra_errs++;
                $display("%s: write of %h to r%0d beyond the expected list",
                         test_name, wb_data, wb_reg);
            end else begin
                check_reg("wb_reg", exp_reg[got], wb_reg);
                check_word("wb_data", exp_val[got], wb_data);
                got++;
            end
        end
    end

    // reset stays asserted while the program is built
    task automatic start_test(input string name);
        @(posedge clock);
        #1 rst_n = 1'b0;
        test_name = name;
        prog_len = 0;
    endtask

    task automatic run_program();
        int executed;
        executed = ref_run();
        budget += 3 * executed;
        got = 0;
        repeat (4) begin
            @(posedge clock);
            check_bit("wb_en in reset", 1'b0, wb_en);
            check_word("imem_addr in reset", RESET_PC, imem_addr);
        end
        #1 rst_n = 1'b1;
        @(posedge clock);
        check_bit("wb_en after reset", 1'b0, wb_en);
        check_word("imem_addr after reset", RESET_PC, imem_addr);
        while (imem_addr !== loop_pc) begin
            @(posedge clock);
        end
        // last write leaves writeback 4 cycles after the loop fetch
        repeat (6) @(posedge clock);
        if (got < exp_reg.size()) begin
            missing_errs += exp_reg.size() - got;
            $display("%s: %0d expected register writes never appeared",
                     test_name, exp_reg.size() - got);
        end
    endtask

    // each result feeds the next one or the one after
    task automatic dependency_test();
        start_test("dependency");
        append_instr(addi_word(1, 0, 3));
        append_instr(addi_word(2, 0, 10));
        append_instr(rtype_word(ALU_ADD, 3, 1, 2));
        append_instr(rtype_word(ALU_SUB, 4, 3, 1));
        append_instr(rtype_word(ALU_AND, 5, 4, 3));
        append_instr(rtype_word(ALU_OR, 6, 5, 2));
        append_instr(rtype_word(ALU_SUB, 7, 1, 6));
        append_instr(rtype_word(ALU_ADD, 1, 7, 7));
        append_instr(rtype_word(ALU_AND, 2, 1, 5));
        append_instr(rtype_word(ALU_OR, 3, 2, 1));
        append_instr(jump_word(10));
        run_program();
    endtask

    task automatic addi_test();
        start_test("addi_sign");
        append_instr(addi_word(1, 0, 'h0FFFF));
        append_instr(addi_word(2, 0, -1));
        append_instr(addi_word(3, 0, -65536));
        // sums that carry out of bit 31
        append_instr(addi_word(4, 2, 2));
        append_instr(addi_word(5, 2, 'h0FFFF));
        append_instr(addi_word(6, 3, -65536));
        append_instr(jump_word(6));
        run_program();
    endtask

    // words at 5, 6, 9 and 10 sit in branch shadows
    task automatic branch_test();
        start_test("control_flow");
        append_instr(addi_word(1, 0, 5));
        append_instr(addi_word(2, 0, 5));
        append_instr(bne_word(2, 1, 3));
        append_instr(addi_word(3, 0, 7));
        append_instr(bne_word(3, 1, 2));
        append_instr(addi_word(4, 0, 99));
        append_instr(addi_word(5, 0, 98));
        append_instr(rtype_word(ALU_ADD, 6, 1, 3));
        append_instr(jump_word(11));
        append_instr(addi_word(4, 0, 77));
        append_instr(addi_word(5, 0, 76));
        append_instr(rtype_word(ALU_OR, 7, 6, 1));
        append_instr(jump_word(12));
        run_program();
    endtask

    task automatic r0_test();
        start_test("r0_hold");
        append_instr(addi_word(0, 0, 123));
        append_instr(addi_word(1, 0, 5));
        append_instr(rtype_word(ALU_ADD, 0, 1, 1));
        append_instr(rtype_word(ALU_OR, 2, 0, 1));
        append_instr(rtype_word(ALU_SUB, 3, 1, 0));
        append_instr(jump_word(5));
        run_program();
    endtask

    // straight-line mix of r-type and addi on r0..r7
    task automatic random_test(input int num);
        int       kind;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        start_test($sformatf("random_%0d", num));
        for (int i = 0; i < 40; i++) begin
            kind = $unsigned($random(seed)) % 5;
            rd = reg_idx_t'($random(seed) & 7);
            rs = reg_idx_t'($random(seed) & 7);
            rt = reg_idx_t'($random(seed) & 7);
            if (kind < 4) begin
                append_instr(rtype_word(alu_op_t'(kind), rd, rs, rt));
            end else begin
                append_instr(addi_word(rd, rs, $random(seed)));
            end
        end
        append_instr(jump_word(40));
        run_program();
    endtask

    initial begin
        rst_n = 1'b0;
        imem_data = NOP_WORD;
        prog_len = 0;
        got = 0;
        loop_pc = '0;
        test_name = "init";
        seed = 18502;
        budget = 20;
        value_errs = 0;
        extra_errs = 0;
        missing_errs = 0;
        dependency_test();
        addi_test();
        branch_test();
        r0_test();
        for (int n = 0; n < 3; n++) begin
            random_test(n);
        end
        $display("errors: %0d value mismatches, %0d unexpected writes, %0d missing writes",
                 value_errs, extra_errs, missing_errs);
        if ((value_errs + extra_errs + missing_errs) == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // budget grows by 3 cycles per executed instruction
    initial begin
        cycles = 0;
        @(posedge clock);
        while (cycles <= budget) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: %s did not finish within %0d cycles", test_name, budget);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- design/pipe_core.sv
//##########################################################################
// top level of the pipelined core
//   fetch unit, register file and execute pipeline
//   instruction memory port and writeback observation port
//##########################################################################

`timescale 1ns/10ps

module pipe_core
    import core_pkg::*;
#(
    parameter word_t RESET_PC = '0,
    parameter int    NUM_REGS = 32
) (
    input  logic     clock,
    input  logic     rst_n,
    output word_t    imem_addr,
    input  word_t    imem_data,
    output logic     wb_en,
    output reg_idx_t wb_reg,
    output word_t    wb_data
);

    // fetch to decode
    word_t    fd_instr;
    word_t    fd_pc;
    // execute back to fetch
    logic     redirect;
    word_t    redirect_pc;
    // register read ports
    reg_idx_t rd_addr_a;
    reg_idx_t rd_addr_b;
    word_t    rd_data_a;
    word_t    rd_data_b;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clock       (clock),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .fd_instr    (fd_instr),
        .fd_pc       (fd_pc)
    );

    // write port shared with the wb_* outputs
    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_regs (
        .clock     (clock),
        .rst_n     (rst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wb_en),
        .wr_reg    (wb_reg),
        .wr_data   (wb_data)
    );

    exec_pipe u_exec (
        .clock       (clock),
        .rst_n       (rst_n),
        .fd_instr    (fd_instr),
        .fd_pc       (fd_pc),
        .rd_addr_a   (rd_addr_a),
        .rd_data_a   (rd_data_a),
        .rd_addr_b   (rd_addr_b),
        .rd_data_b   (rd_data_b),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wr_en       (wb_en),
        .wr_reg      (wb_reg),
        .wr_data     (wb_data)
    );

endmodule

//--- design/exec_pipe.sv
//##########################################################################
// decode through writeback
//   register reads and decode/execute register
//   operand bypass from memory and writeback stages
//   alu, branch resolution and redirect
//   execute/memory and memory/writeback registers, write port
//##########################################################################

`timescale 1ns/10ps

module exec_pipe
    import core_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  word_t    fd_instr,
    input  word_t    fd_pc,
    output reg_idx_t rd_addr_a,
    input  word_t    rd_data_a,
    output reg_idx_t rd_addr_b,
    input  word_t    rd_data_b,
    output logic     redirect,
    output word_t    redirect_pc,
    output logic     wr_en,
    output reg_idx_t wr_reg,
    output word_t    wr_data
);

    // decode stage fields
    opcode_t  d_op;
    reg_idx_t d_rd;
    reg_idx_t d_rt;

    // execute stage
    word_t    x_instr;
    word_t    x_pc;
    word_t    x_a;
    word_t    x_b;
    opcode_t  x_op;
    reg_idx_t x_rd;
    reg_idx_t x_rs;
    reg_idx_t x_src_b;
    word_t    x_imm;
    word_t    x_target;
    word_t    fwd_a;
    word_t    fwd_b;
    word_t    alu_b;
    alu_op_t  alu_op;
    word_t    alu_result;
    logic     alu_ne;
    logic     x_wr;

    // memory and writeback stages
    logic     m_wr;
    reg_idx_t m_rd;
    word_t    m_result;
    logic     w_wr;
    reg_idx_t w_rd;
    word_t    w_result;

    assign d_op = fd_instr[OPCODE_MSB:OPCODE_LSB];
    assign d_rd = fd_instr[RD_MSB:RD_LSB];
    assign d_rt = fd_instr[RT_MSB:RT_LSB];

    // port b reads rd for bne so rs and rd can be compared
    assign rd_addr_a = fd_instr[RS_MSB:RS_LSB];
    assign rd_addr_b = (d_op == OP_BNE) ? d_rd : d_rt;

    // decode/execute, squashed by a taken branch in execute
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            x_instr <= NOP_WORD;
        end else if (redirect) begin
            x_instr <= NOP_WORD;
        end else begin
            x_instr <= fd_instr;
        end
    end

    always_ff @(posedge clock) begin
        x_pc <= fd_pc;
        x_a  <= rd_data_a;
        x_b  <= rd_data_b;
    end

    assign x_op     = x_instr[OPCODE_MSB:OPCODE_LSB];
    assign x_rd     = x_instr[RD_MSB:RD_LSB];
    assign x_rs     = x_instr[RS_MSB:RS_LSB];
    assign x_src_b  = (x_op == OP_BNE) ? x_rd : x_instr[RT_MSB:RT_LSB];
    assign x_imm    = {{(WORD_W-IMM_W){x_instr[IMM_MSB]}}, x_instr[IMM_MSB:0]};
    assign x_target = {{(WORD_W-TARGET_MSB-1){1'b0}}, x_instr[TARGET_MSB:0]};

    // younger producer in memory beats older one in writeback
    // m_wr and w_wr already exclude r0
    function automatic word_t bypass(reg_idx_t src, word_t file_val);
        if (m_wr && (m_rd == src)) begin
            return m_result;
        end
        if (w_wr && (w_rd == src)) begin
            return w_result;
        end
        return file_val;
    endfunction

    assign fwd_a = bypass(x_rs, x_a);
    assign fwd_b = bypass(x_src_b, x_b);
    assign alu_b = (x_op == OP_ADDI) ? x_imm : fwd_b;

    // r-type takes the function field, bne compares by subtracting
    always_comb begin
        case (x_op)
            OP_RTYPE: alu_op = x_instr[FUNC_MSB:FUNC_LSB];
            OP_BNE:   alu_op = ALU_SUB;
            default:  alu_op = ALU_ADD;
        endcase
    end

    alu u_alu (
        .operand_a (fwd_a),
        .operand_b (alu_b),
        .op        (alu_op),
        .result    (alu_result),
        .not_equal (alu_ne)
    );

    // branch resolution
    assign redirect    = (x_op == OP_J) || ((x_op == OP_BNE) && alu_ne);
    assign redirect_pc = (x_op == OP_J) ? x_target : x_pc + word_t'(1) + x_imm;

    // only r-type and addi write, never to r0
    assign x_wr = ((x_op == OP_RTYPE) || (x_op == OP_ADDI)) && (x_rd != '0);

    // execute/memory then memory/writeback
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            m_wr <= 1'b0;
            m_rd <= '0;
            w_wr <= 1'b0;
            w_rd <= '0;
        end else begin
            m_wr <= x_wr;
            m_rd <= x_rd;
            w_wr <= m_wr;
            w_rd <= m_rd;
        end
    end

    always_ff @(posedge clock) begin
        m_result <= alu_result;
        w_result <= m_result;
    end

    assign wr_en   = w_wr;
    assign wr_reg  = w_rd;
    assign wr_data = w_result;

    // a taken branch always carries a defined target
    a_target_known: assert property (@(posedge clock) disable iff (!rst_n)
        redirect |-> !$isunknown(redirect_pc));

endmodule

//--- design/reg_file.sv
//##########################################################################
// register file
//   two combinational read ports with write-through
//   one write port, r0 held at zero
//##########################################################################

`timescale 1ns/10ps

module reg_file
    import core_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic     clock,
    input  logic     rst_n,
    input  reg_idx_t rd_addr_a,
    input  reg_idx_t rd_addr_b,
    output word_t    rd_data_a,
    output word_t    rd_data_b,
    input  logic     wr_en,
    input  reg_idx_t wr_reg,
    input  word_t    wr_data
);

    word_t regs [NUM_REGS];

    // decode sees the value writeback is storing this cycle
    function automatic word_t read_port(reg_idx_t addr);
        if (wr_en && (wr_reg == addr) && (addr != '0)) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    assign rd_data_a = read_port(rd_addr_a);
    assign rd_data_b = read_port(rd_addr_b);

    // writes to r0 dropped
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_reg != '0)) begin
            regs[wr_reg] <= wr_data;
        end
    end

    a_wr_in_range: assert property (@(posedge clock) disable iff (!rst_n)
        wr_en |-> (int'(wr_reg) < NUM_REGS));

endmodule

//--- design/fetch_unit.sv
//##########################################################################
// fetch stage
//   program counter with next-pc select
//   fetch/decode pipeline register with branch squash
//##########################################################################

`timescale 1ns/10ps

module fetch_unit
    import core_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  redirect,
    input  word_t redirect_pc,
    output word_t imem_addr,
    input  word_t imem_data,
    output word_t fd_instr,
    output word_t fd_pc
);

    word_t pc;
    word_t pc_next;

    // taken branch or jump from execute wins over pc + 1
    assign pc_next = redirect ? redirect_pc : pc + word_t'(1);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // instruction memory answers in the same cycle
    assign imem_addr = pc;

    // fetch/decode instruction
    // word fetched behind a taken branch becomes a no-op
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fd_instr <= NOP_WORD;
        end else if (redirect) begin
            fd_instr <= NOP_WORD;
        end else begin
            fd_instr <= imem_data;
        end
    end

    // pc travels with the instruction for bne targets
    always_ff @(posedge clock) begin
        fd_pc <= pc;
    end

    // execute must always send a defined target
    a_pc_known: assert property (@(posedge clock) disable iff (!rst_n)
        !$isunknown(pc));

endmodule

//--- design/alu.sv
//##########################################################################
// integer alu
//   add, sub, and, or with wrap-around
//   not-equal flag for bne
//##########################################################################

`timescale 1ns/10ps

module alu
    import core_pkg::*;
(
    input  word_t   operand_a,
    input  word_t   operand_b,
    input  alu_op_t op,
    output word_t   result,
    output logic    not_equal
);

    word_t diff;

    // one subtractor serves sub and the compare
    assign diff = operand_a - operand_b;

    always_comb begin
        case (op)
            ALU_ADD: result = operand_a + operand_b;
            ALU_SUB: result = diff;
            ALU_AND: result = operand_a & operand_b;
            ALU_OR:  result = operand_a | operand_b;
            default: result = '0;
        endcase
    end

    // nonzero difference, operands differ
    assign not_equal = |diff;

    // execute forces add or sub for every non r-type opcode
    always_comb begin
        a_op_legal: assert #0 ($isunknown(op) ||
                               (op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR}))
            else $error("alu op %0d outside the supported set", op);
    end

endmodule

//--- design/core_pkg.sv
//##########################################################################
// shared definitions for the five-stage integer core
//   word and register-index types
//   opcode and alu operation codes
//   instruction field positions and the no-op word
//##########################################################################

package core_pkg;

    // data and address width
    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [4:0]           opcode_t;
    typedef logic [4:0]           alu_op_t;

    // opcodes still decoded
    localparam opcode_t OP_RTYPE = 5'd0;
    localparam opcode_t OP_J     = 5'd1;
    localparam opcode_t OP_BNE   = 5'd2;
    localparam opcode_t OP_ADDI  = 5'd5;

    // alu function field of r-type
    localparam alu_op_t ALU_ADD = 5'd0;
    localparam alu_op_t ALU_SUB = 5'd1;
    localparam alu_op_t ALU_AND = 5'd2;
    localparam alu_op_t ALU_OR  = 5'd3;

    // field positions
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 27;
    localparam int RD_MSB     = 26;
    localparam int RD_LSB     = 22;
    localparam int RS_MSB     = 21;
    localparam int RS_LSB     = 17;
    localparam int RT_MSB     = 16;
    localparam int RT_LSB     = 12;
    localparam int FUNC_MSB   = 6;
    localparam int FUNC_LSB   = 2;
    // immediate sits in 16:0, sign extended
    localparam int IMM_MSB    = 16;
    localparam int IMM_W      = 17;
    // jump target in 26:0, zero extended
    localparam int TARGET_MSB = 26;

    // add r0 <- r0 + r0, never writes
    localparam word_t NOP_WORD = '0;

endpackage
